//--- Makefile
# Verilator build and run of the RV32I pipeline testbench
SIM = obj_dir/rv_core_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module rv_core_tb \
		-f compile.f -Mdir obj_dir -o rv_core_sim

run: compile
	./$(SIM) | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- compile.f
design/rv_core_pkg.sv
design/rv_stage_if.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_writeback.sv
design/rv_core_top.sv
test/rv_core_assert.sv
test/rv_core_tb.sv

//--- design/rv_core_pkg.sv
/* Opcodes, ALU selects, instruction views and stage payloads for the RV32I pipeline
   Every stage, the top level and the testbench import what they need from here */
package rv_core_pkg;

    // ============================================================
    // Major opcodes, low two bits included
    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;

    // Receiver queue depth and initial sender credit
    localparam int CREDITS = 2;
    localparam int PTR_W   = $clog2(CREDITS);     // Queue pointer width
    localparam int CNT_W   = $clog2(CREDITS + 1); // Holds 0..CREDITS

    // ALU function, uns picks unsigned compare or logical shift
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_SLL = 3'd2,
        ALU_SLT = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SHR = 3'd5,
        ALU_OR  = 3'd6,
        ALU_AND = 3'd7
    } alu_sel_t;

    // ============================================================
    // Instruction word, R view and U view of the same 32 bits
    typedef struct packed {
        logic [6:0] funct7;  // Also I-imm [11:5]
        logic [4:0] rs2;     // Also I-imm [4:0]
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef union packed {
        r_type_t r_fields;
        u_type_t u_fields;
    } instr_t;

    // ============================================================
    // Stage payloads
    typedef struct packed {
        instr_t      ir;
        logic [31:0] pc;
    } fetch_t;

    typedef struct packed {
        logic [31:0] op1;
        logic [31:0] op2;
        alu_sel_t    sel;
        logic        uns;
        logic [4:0]  rd;
        logic        rd_write;
        logic        illegal;
        logic [31:0] pc;
    } issue_t;

    typedef struct packed {
        logic [31:0] data;
        logic [4:0]  rd;
        logic        rd_write;
        logic        illegal;
        logic [31:0] pc;
    } result_t;

endpackage

//--- design/rv_core_top.sv
/* Top level of the RV32I pipeline: decode, execute and writeback joined by
   credit links, with plain fetch and retire ports toward the outside */
`timescale 1ns/1ns

module rv_core_top (
    input  logic                clk,
    input  logic                rstz,
    // Fetch side
    input  logic                instr_vld,
    input  rv_core_pkg::instr_t instr,
    input  logic [31:0]         pc,
    output logic                instr_credit,
    // Retire side
    output logic                retire_vld,
    output logic [31:0]         retire_pc,
    output logic [4:0]          retire_rd,
    output logic [31:0]         retire_data,
    output logic                retire_illegal,
    input  logic                retire_credit
);
    import rv_core_pkg::*;

    // Register write back into decode
    logic        wr_en;
    logic [4:0]  wr_rd;
    logic [31:0] wr_data;

    rv_stage_if #(.T(issue_t))  ix_if ();  // Decode to execute
    rv_stage_if #(.T(result_t)) xw_if ();  // Execute to writeback

    rv_decode u_decode (
        .clk          (clk),
        .rstz         (rstz),
        .instr_vld    (instr_vld),
        .instr        (instr),
        .pc           (pc),
        .instr_credit (instr_credit),
        .ix           (ix_if.sender),
        .wr_en        (wr_en),
        .wr_rd        (wr_rd),
        .wr_data      (wr_data)
    );

    rv_execute u_execute (
        .clk  (clk),
        .rstz (rstz),
        .ix   (ix_if.receiver),
        .xw   (xw_if.sender)
    );

    rv_writeback u_writeback (
        .clk            (clk),
        .rstz           (rstz),
        .retire_credit  (retire_credit),
        .xw             (xw_if.receiver),
        .wr_en          (wr_en),
        .wr_rd          (wr_rd),
        .wr_data        (wr_data),
        .retire_vld     (retire_vld),
        .retire_pc      (retire_pc),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data),
        .retire_illegal (retire_illegal)
    );

endmodule

//--- design/rv_decode.sv
/* Decode stage: queues fetched words, reads operands, tracks busy registers
   and issues one decoded instruction per cycle to execute over the ix link */
`timescale 1ns/1ns

module rv_decode (
    input  logic                clk,
    input  logic                rstz,
    input  logic                instr_vld,
    input  rv_core_pkg::instr_t instr,
    input  logic [31:0]         pc,
    output logic                instr_credit,
    rv_stage_if.sender          ix,
    input  logic                wr_en,
    input  logic [4:0]          wr_rd,
    input  logic [31:0]         wr_data
);
    import rv_core_pkg::*;

    fetch_t           q_mem [CREDITS];  // Input queue, no fall-through
    logic [PTR_W-1:0] q_wp, q_rp;
    logic [CNT_W-1:0] q_cnt;
    fetch_t           head;
    instr_t           ir;
    logic [6:0]       opc, funct7;
    logic [2:0]       funct3;
    logic [4:0]       rs1, rs2, rd;
    logic             is_op, is_opimm, is_lui, is_auipc;
    logic             f7_zero, f7_alt;
    logic             legal, rd_write, uses_rs1, uses_rs2;
    alu_sel_t         sel;
    logic             uns;
    logic [31:0]      imm_i, imm_u, rs1_data, rs2_data;
    logic [31:0]      rf [32];
    logic [31:0]      busy, busy_eff, rel_mask, set_mask;
    logic             blocked, issue;
    logic [CNT_W-1:0] ix_cnt;           // Credits toward execute

    // ============================================================
    // Input queue
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            q_wp  <= '0;
            q_rp  <= '0;
            q_cnt <= '0;
        end else begin
            if (instr_vld) q_wp <= q_wp + PTR_W'(1);
            if (issue) q_rp <= q_rp + PTR_W'(1);  // Pop on issue
            q_cnt <= q_cnt + CNT_W'(instr_vld) - CNT_W'(issue);
        end
    end

    always_ff @(posedge clk) begin
        if (instr_vld) q_mem[q_wp] <= '{ir: instr, pc: pc};
    end

    assign head = q_mem[q_rp];
    assign ir   = head.ir;

    // ============================================================
    // Field views and immediates
    assign opc    = ir.r_fields.opcode;
    assign funct7 = ir.r_fields.funct7;
    assign funct3 = ir.r_fields.funct3;
    assign rs1    = ir.r_fields.rs1;
    assign rs2    = ir.r_fields.rs2;
    assign rd     = ir.r_fields.rd;

    assign is_op    = opc == OPC_OP;
    assign is_opimm = opc == OPC_OPIMM;
    assign is_lui   = opc == OPC_LUI;
    assign is_auipc = opc == OPC_AUIPC;
    assign f7_zero  = funct7 == 7'h00;
    assign f7_alt   = funct7 == 7'h20;  // SUB / SRA encoding

    assign imm_i = {{20{funct7[6]}}, funct7, rs2};   // Sign-extended I-imm
    assign imm_u = {ir.u_fields.imm20, 12'h000};

    // ALU select and legality from funct3 / funct7
    always_comb begin
        sel   = ALU_ADD;
        uns   = 1'b0;
        legal = is_lui || is_auipc;
        if (is_op || is_opimm) begin
            case (funct3)
                3'b000: begin
                    sel   = (is_op && funct7[5]) ? ALU_SUB : ALU_ADD;
                    legal = is_opimm || f7_zero || f7_alt;  // ADDI has no SUB form
                end
                3'b001: begin
                    sel   = ALU_SLL;
                    legal = f7_zero;
                end
                3'b010: begin
                    sel   = ALU_SLT;
                    legal = is_opimm || f7_zero;
                end
                3'b011: begin
                    sel   = ALU_SLT;
                    uns   = 1'b1;                           // SLTU / SLTIU
                    legal = is_opimm || f7_zero;
                end
                3'b100: begin
                    sel   = ALU_XOR;
                    legal = is_opimm || f7_zero;
                end
                3'b101: begin
                    sel   = ALU_SHR;
                    uns   = ~funct7[5];                     // SRL vs SRA
                    legal = f7_zero || f7_alt;
                end
                3'b110: begin
                    sel   = ALU_OR;
                    legal = is_opimm || f7_zero;
                end
                default: begin
                    sel   = ALU_AND;
                    legal = is_opimm || f7_zero;
                end
            endcase
        end
    end

    assign rd_write = legal && (rd != 5'd0);    // x0 never written or marked
    assign uses_rs1 = is_op || is_opimm;
    assign uses_rs2 = is_op;

    // ============================================================
    // Register file, write-through read, x0 reads zero
    always_ff @(posedge clk) begin
        if (wr_en && wr_rd != 5'd0) rf[wr_rd] <= wr_data;
    end

    assign rs1_data = (rs1 == 5'd0) ? '0 :
                      (wr_en && wr_rd == rs1) ? wr_data : rf[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 :
                      (wr_en && wr_rd == rs2) ? wr_data : rf[rs2];

    // ============================================================
    // Scoreboard and issue
    assign rel_mask = wr_en ? (32'd1 << wr_rd) : '0;           // Writeback release
    assign set_mask = (issue && rd_write) ? (32'd1 << rd) : '0;
    assign busy_eff = busy & ~rel_mask;  // Released reg readable this cycle

    // Stall on busy sources, and on busy rd to keep one owner per reg
    assign blocked = (uses_rs1 && busy_eff[rs1]) ||
                     (uses_rs2 && busy_eff[rs2]) ||
                     (rd_write && busy_eff[rd]);
    assign issue   = (q_cnt != '0) && (ix_cnt != '0) && !blocked;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            ix.vld       <= 1'b0;
            instr_credit <= 1'b0;
            ix_cnt       <= CNT_W'(CREDITS);
            busy         <= '0;
        end else begin
            ix.vld       <= issue;
            instr_credit <= issue;   // Queue slot freed by this pop
            ix_cnt       <= ix_cnt - CNT_W'(issue) + CNT_W'(ix.credit);
            busy         <= busy_eff | set_mask;   // Set wins over release
        end
    end

    // Issue register, operand choice per opcode
    always_ff @(posedge clk) begin
        if (issue) begin
            ix.payload <= '{
                op1:      is_lui ? 32'd0 : (is_auipc ? head.pc : rs1_data),
                op2:      is_op ? rs2_data : (is_opimm ? imm_i : imm_u),
                sel:      sel,
                uns:      uns,
                rd:       rd,
                rd_write: rd_write,
                illegal:  ~legal,
                pc:       head.pc
            };
        end
    end

endmodule

//--- design/rv_execute.sv
/* Execute stage: queues issued instructions, runs the ALU and registers
   the result toward writeback over the xw link */
`timescale 1ns/1ns

module rv_execute (
    input  logic          clk,
    input  logic          rstz,
    rv_stage_if.receiver  ix,
    rv_stage_if.sender    xw
);
    import rv_core_pkg::*;

    issue_t           q_mem [CREDITS];
    logic [PTR_W-1:0] q_wp, q_rp;
    logic [CNT_W-1:0] q_cnt;
    issue_t           head;
    logic             head_vld, pop;
    logic [CNT_W-1:0] xw_cnt;    // Credits toward writeback
    logic [4:0]       shamt;
    logic [31:0]      alu_out;

    // ============================================================
    // Input queue, empty queue passes the arriving entry straight to head
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            q_wp  <= '0;
            q_rp  <= '0;
            q_cnt <= '0;
        end else begin
            if (ix.vld) q_wp <= q_wp + PTR_W'(1);
            if (pop) q_rp <= q_rp + PTR_W'(1);
            q_cnt <= q_cnt + CNT_W'(ix.vld) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (ix.vld) q_mem[q_wp] <= ix.payload;
    end

    assign head_vld = (q_cnt != '0) || ix.vld;
    assign head     = (q_cnt == '0) ? ix.payload : q_mem[q_rp];
    assign pop      = head_vld && (xw_cnt != '0);

    // ============================================================
    // ALU
    assign shamt = head.op2[4:0];   // Low 5 bits only

    always_comb begin
        case (head.sel)
            ALU_ADD: alu_out = head.op1 + head.op2;
            ALU_SUB: alu_out = head.op1 - head.op2;
            ALU_SLL: alu_out = head.op1 << shamt;
            ALU_SLT: begin
                if (head.uns) alu_out = {31'd0, head.op1 < head.op2};
                else alu_out = {31'd0, $signed(head.op1) < $signed(head.op2)};
            end
            ALU_XOR: alu_out = head.op1 ^ head.op2;
            ALU_SHR: begin
                if (head.uns) alu_out = head.op1 >> shamt;        // SRL
                else alu_out = $unsigned($signed(head.op1) >>> shamt);  // SRA
            end
            ALU_OR:  alu_out = head.op1 | head.op2;
            default: alu_out = head.op1 & head.op2;
        endcase
    end

    // ============================================================
    // Result register and credit handling
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            xw.vld    <= 1'b0;
            ix.credit <= 1'b0;
            xw_cnt    <= CNT_W'(CREDITS);
        end else begin
            xw.vld    <= pop;
            ix.credit <= pop;   // Same cycle as the result
            xw_cnt    <= xw_cnt - CNT_W'(pop) + CNT_W'(xw.credit);
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            xw.payload <= '{
                data:     alu_out,
                rd:       head.rd,
                rd_write: head.rd_write,
                illegal:  head.illegal,
                pc:       head.pc
            };
        end
    end

endmodule

//--- design/rv_stage_if.sv
/* One credit-flow link between two pipeline stages
   Sender spends a credit per valid, receiver returns one per queue pop */
`timescale 1ns/1ns

interface rv_stage_if #(
    parameter type T = logic    // Payload carried on the link
);

    logic vld;      // One-cycle push into the receiver queue
    T     payload;  // Meaningful only with vld
    logic credit;   // One-cycle pulse per pop on the receive side

    modport sender (
        output vld,
        output payload,
        input  credit
    );

    modport receiver (
        input  vld,
        input  payload,
        output credit
    );

endinterface

//--- design/rv_writeback.sv
/* Writeback stage: queues results, writes the register file, frees the
   scoreboard entry and retires in order under consumer credit */
`timescale 1ns/1ns

module rv_writeback (
    input  logic          clk,
    input  logic          rstz,
    input  logic          retire_credit,
    rv_stage_if.receiver  xw,
    output logic          wr_en,
    output logic [4:0]    wr_rd,
    output logic [31:0]   wr_data,
    output logic          retire_vld,
    output logic [31:0]   retire_pc,
    output logic [4:0]    retire_rd,
    output logic [31:0]   retire_data,
    output logic          retire_illegal
);
    import rv_core_pkg::*;

    result_t          q_mem [CREDITS];
    logic [PTR_W-1:0] q_wp, q_rp;
    logic [CNT_W-1:0] q_cnt;
    result_t          head;
    logic             pop;
    logic [CNT_W-1:0] ret_cnt;   // Credits toward the retire consumer

    // ============================================================
    // Input queue with pass-through head, retire credit counter
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            q_wp    <= '0;
            q_rp    <= '0;
            q_cnt   <= '0;
            ret_cnt <= CNT_W'(CREDITS);
        end else begin
            if (xw.vld) q_wp <= q_wp + PTR_W'(1);
            if (pop) q_rp <= q_rp + PTR_W'(1);
            q_cnt   <= q_cnt + CNT_W'(xw.vld) - CNT_W'(pop);
            ret_cnt <= ret_cnt - CNT_W'(pop) + CNT_W'(retire_credit);
        end
    end

    always_ff @(posedge clk) begin
        if (xw.vld) q_mem[q_wp] <= xw.payload;
    end

    assign head = (q_cnt == '0) ? xw.payload : q_mem[q_rp];
    assign pop  = ((q_cnt != '0) || xw.vld) && (ret_cnt != '0);

    assign xw.credit = pop;

    // Register write and scoreboard release share wr_en
    assign wr_en   = pop && head.rd_write;
    assign wr_rd   = head.rd;
    assign wr_data = head.data;

    assign retire_vld     = pop;
    assign retire_pc      = head.pc;
    assign retire_rd      = head.rd_write ? head.rd : 5'd0;
    assign retire_data    = head.data;
    assign retire_illegal = head.illegal;

endmodule

//--- test/rv_core_assert.sv
/* Credit and retire-order checks on the pipeline boundary ports
   Bound into every rv_core_top instance by the bind below */
`timescale 1ns/1ns

module rv_core_assert (
    input logic        clk,
    input logic        rstz,
    input logic        instr_vld,
    input logic        instr_credit,
    input logic        retire_vld,
    input logic        retire_credit,
    input logic [31:0] retire_pc
);
    import rv_core_pkg::*;

    int          fetch_used, fetch_given;   // Fetch side valids and returned credits
    int          ret_used, ret_given;       // Retire side
    logic [31:0] last_pc;
    logic        seen_retire;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            fetch_used  <= 0;
            fetch_given <= 0;
            ret_used    <= 0;
            ret_given   <= 0;
            last_pc     <= '0;
            seen_retire <= 1'b0;
        end else begin
            if (instr_vld) fetch_used <= fetch_used + 1;
            if (instr_credit) fetch_given <= fetch_given + 1;
            if (retire_vld) ret_used <= ret_used + 1;
            if (retire_credit) ret_given <= ret_given + 1;
            if (retire_vld) begin
                last_pc     <= retire_pc;
                seen_retire <= 1'b1;
            end
        end
    end

    // ============================================================
    a_fetch_credit: assert property (@(posedge clk) disable iff (!rstz)
        instr_vld |-> fetch_used < fetch_given + CREDITS)
        else $error("instr_vld sent without a fetch credit in hand");

    a_retire_credit: assert property (@(posedge clk) disable iff (!rstz)
        retire_vld |-> ret_used < ret_given + CREDITS)
        else $error("retire_vld beyond the credits returned by the consumer");

    // Fetch pc steps by 4, so program order means +4 per retire
    a_retire_order: assert property (@(posedge clk) disable iff (!rstz)
        (retire_vld && seen_retire) |-> retire_pc == last_pc + 32'd4)
        else $error("retire out of program order");

endmodule

bind rv_core_top rv_core_assert u_core_assert (
    .clk           (clk),
    .rstz          (rstz),
    .instr_vld     (instr_vld),
    .instr_credit  (instr_credit),
    .retire_vld    (retire_vld),
    .retire_credit (retire_credit),
    .retire_pc     (retire_pc)
);

//--- test/rv_core_tb.sv
/* Random-program testbench for the RV32I pipeline that checks every retire
   against an in-order model run at send time */
`timescale 1ns/1ns

module rv_core_tb;
    import rv_core_pkg::*;

    localparam int NUM_INSTR   = 400;
    localparam int CYCLE_LIMIT = NUM_INSTR * 40;  // Generous for random credit gaps

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;       // 0 when nothing is written
        logic [31:0] data;
        logic        illegal;
    } expect_t;

    logic        clk, rstz;
    logic        instr_vld, instr_credit;
    instr_t      instr;
    logic [31:0] pc;
    logic        retire_vld, retire_illegal, retire_credit;
    logic [31:0] retire_pc, retire_data;
    logic [4:0]  retire_rd;

    expect_t     exp_q [$];    // Expected retires in program order
    logic [31:0] regs [32];    // Architectural register model
    logic [31:0] lfsr;
    logic [31:0] next_pc;
    int          sent, retired, fetch_cnt, pending, cycles;

    rv_core_top dut0 (
        .clk            (clk),
        .rstz           (rstz),
        .instr_vld      (instr_vld),
        .instr          (instr),
        .pc             (pc),
        .instr_credit   (instr_credit),
        .retire_vld     (retire_vld),
        .retire_pc      (retire_pc),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data),
        .retire_illegal (retire_illegal),
        .retire_credit  (retire_credit)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    // ============================================================
    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // RV32I integer op semantics with alt as the funct7[5] variant
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  r = (a < b) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            3'b101:  r = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // Random instruction on x0..x7 that the model executes right away
    task automatic build_instr(input logic [31:0] ipc, output instr_t w, output expect_t e);
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [1:0]  pick;
        logic [11:0] imm;
        logic [19:0] imm20;
        logic        alt, bad;
        logic [31:0] res;
        rd    = 5'(rand_bits(3));
        rs1   = 5'(rand_bits(3));
        rs2   = 5'(rand_bits(3));
        f3    = 3'(rand_bits(3));
        alt   = rand_bits(1) == 32'd1;
        imm   = 12'(rand_bits(12));
        imm20 = 20'(rand_bits(20));
        bad   = rand_bits(4) == 32'd0;     // About 1 in 16
        pick  = 2'(rand_bits(2));
        res   = '0;
        if (bad) begin
            case (pick)
                2'd0:    w = {7'h01, rs2, rs1, f3, rd, OPC_OP};          // M extension
                2'd1:    w = {7'h00, rs2, rs1, f3, rd, 7'b0110000};      // Low bits 00
                2'd2:    w = {imm, rs1, 3'b010, rd, 7'b0000011};         // LW
                default: w = {7'h20, rs2, rs1, 3'b001, rd, OPC_OPIMM};   // SLLI with bad funct7
            endcase
        end else if (pick[1] == 1'b0) begin
            alt = alt && (f3 == 3'b000 || f3 == 3'b101);   // Only SUB and SRA
            w   = {alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, OPC_OP};
            res = alu_model(f3, alt, regs[rs1], regs[rs2]);
        end else if (pick == 2'd2) begin
            if (f3 == 3'b001) imm[11:5] = 7'h00;
            if (f3 == 3'b101) imm[11:5] = alt ? 7'h20 : 7'h00;  // SRAI / SRLI
            w   = {imm, rs1, f3, rd, OPC_OPIMM};
            res = alu_model(f3, f3 == 3'b101 && alt, regs[rs1], {{20{imm[11]}}, imm});
        end else begin
            w   = {imm20, rd, alt ? OPC_AUIPC : OPC_LUI};
            res = alt ? ipc + {imm20, 12'h000} : {imm20, 12'h000};
        end
        if (!bad && rd != 5'd0) regs[rd] = res;
        e.pc      = ipc;
        e.rd      = bad ? 5'd0 : rd;
        e.data    = res;
        e.illegal = bad;
    endtask

    // ============================================================
    // Checking
    task automatic fail_run();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_retire();
        expect_t e;
        a_outstanding: assert (exp_q.size() != 0) else begin
            $display("Retire at %0t with pc %h while nothing was outstanding",
                     $time, retire_pc);
            fail_run();
        end
        e = exp_q.pop_front();
        a_pc: assert (retire_pc == e.pc) else begin
            $display("FAILED at %0t: retire pc %h, expected %h", $time, retire_pc, e.pc);
            fail_run();
        end
        a_ill: assert (retire_illegal == e.illegal) else begin
            $display("FAILED at %0t: pc %h illegal %b, expected %b",
                     $time, e.pc, retire_illegal, e.illegal);
            fail_run();
        end
        a_rd: assert (retire_rd == e.rd) else begin
            $display("FAILED at %0t: pc %h rd %0d, expected %0d",
                     $time, e.pc, retire_rd, e.rd);
            fail_run();
        end
        a_data: assert (e.illegal || retire_data == e.data) else begin
            $display("FAILED at %0t: pc %h data %h, expected %h",
                     $time, e.pc, retire_data, e.data);
            fail_run();
        end
    endtask

    // ============================================================
    // Stimulus and main loop
    initial begin
        instr_t  w;
        expect_t e;
        int      i;
        rstz          = 1'b0;
        instr_vld     = 1'b0;
        instr         = '0;
        pc            = '0;
        retire_credit = 1'b0;
        lfsr          = 32'h62de_e64f;
        next_pc       = 32'h0000_1000;
        sent          = 0;
        retired       = 0;
        fetch_cnt     = CREDITS;   // Fetch side starts full
        pending       = 0;         // Retired with credit not yet returned
        cycles        = 0;
        for (i = 0; i < 32; i++) regs[i] = '0;

        repeat (8) @(posedge clk);
        rstz <= 1'b1;

        while (retired < NUM_INSTR && cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
            if (instr_credit) fetch_cnt++;
            a_fetch: assert (fetch_cnt <= CREDITS) else begin
                $display("More fetch credits came back than instructions were sent at %0t",
                         $time);
                fail_run();
            end
            if (retire_vld) begin
                check_retire();
                retired++;
                pending++;
            end
            // Send on a held credit with random gaps
            if (sent < NUM_INSTR && fetch_cnt > 0 && rand_bits(2) != 32'd0) begin
                build_instr(next_pc, w, e);
                exp_q.push_back(e);
                instr_vld <= 1'b1;
                instr     <= w;
                pc        <= next_pc;
                next_pc   = next_pc + 32'd4;
                fetch_cnt--;
                sent++;
            end else begin
                instr_vld <= 1'b0;
            end
            // Consumer hands back slots on random cycles
            if (pending > 0 && rand_bits(1) == 32'd1) begin
                retire_credit <= 1'b1;
                pending--;
            end else begin
                retire_credit <= 1'b0;
            end
        end

        if (retired == NUM_INSTR) begin
            $display("test passed");
            $finish;
        end else begin
            $display("Timed out after %0d cycles with %0d of %0d instructions retired",
                     cycles, retired, NUM_INSTR);
            fail_run();
        end
    end

endmodule
